// File: src/vcu_pkg.sv
package vcu_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int LANES       = 8;
    localparam int LANE_W      = 16;
    localparam int ADDR_W      = 12;
    localparam int PROG_ADDR_W = 10;
    localparam int PROG_LEN_W  = 5;
    localparam int INSN_W      = 64;

    typedef logic signed [LANE_W-1:0] lane_t;
    typedef lane_t [LANES-1:0] vec_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOAD    = 3'd1,
        ST_COMPUTE = 3'd2,
        ST_WRITE   = 3'd3,
        ST_CONFIG  = 3'd4
    } vcu_state_e;

    typedef enum logic {
        KIND_COMPUTE = 1'b0,
        KIND_CONFIG  = 1'b1
    } vcu_kind_e;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD_C = 4'd1,
        OP_MUL_C = 4'd2,
        OP_MAX_C = 4'd3,
        OP_SAVE  = 4'd4,
        OP_ADD_S = 4'd5
    } vcu_op_e;

    typedef struct packed {
        vcu_op_e     op;
        logic [11:0] rsvd;
    } vcu_microop_t;

    // 64-bit compute view
    typedef struct packed {
        vcu_kind_e              kind;
        logic                   xform;
        logic [ADDR_W-1:0]      src_addr;
        logic [ADDR_W-1:0]      dst_addr;
        logic [ADDR_W-1:0]      count;
        logic [PROG_ADDR_W-1:0] prog_addr;
        logic [PROG_LEN_W-1:0]  prog_len;
        logic [10:0]            rsvd;
    } vcu_insn_t;

    // config view of the same word
    typedef struct packed {
        vcu_kind_e   kind;
        logic [14:0] rsvd;
        lane_t       add_const;
        lane_t       mul_const;
        lane_t       cmp_const;
    } vcu_config_t;

    typedef struct packed {
        lane_t add_const;
        lane_t mul_const;
        lane_t cmp_const;
    } vcu_consts_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } ram_rd_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        vec_t              data;
    } ram_wr_t;

    typedef struct packed {
        logic                   en;
        logic [PROG_ADDR_W-1:0] addr;
        vcu_microop_t           data;
    } prog_wr_t;

endpackage

// File: src/vcu_insn_regs.sv
`timescale 1ns/10ps

module vcu_insn_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  logic                cfg_load,
    input  vcu_pkg::vcu_insn_t  insn_in,
    output vcu_pkg::vcu_insn_t  insn,
    output vcu_pkg::vcu_consts_t consts
);
    import vcu_pkg::*;

    logic [INSN_W-1:0] held;
    vcu_config_t       cfg;

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            held <= insn_in;
        end
    end

    // two views of the held word
    assign insn = vcu_insn_t'(held);
    assign cfg  = vcu_config_t'(held);

    // constants persist across compute instructions
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            consts.add_const <= lane_t'(0);
            consts.mul_const <= lane_t'(1);
            consts.cmp_const <= lane_t'(0);
        end
        else if (cfg_load)
        begin
            consts.add_const <= cfg.add_const;
            consts.mul_const <= cfg.mul_const;
            consts.cmp_const <= cfg.cmp_const;
        end
    end

endmodule

// File: src/vcu_ctrl.sv
`timescale 1ns/10ps

module vcu_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        work_en,
    input  vcu_pkg::vcu_insn_t          insn,
    output logic                        capture,
    output logic                        cfg_load,
    output vcu_pkg::ram_rd_t            acc_rd,
    output logic                        lane_load,
    output logic                        seq_start,
    input  logic                        seq_done,
    output logic                        wr_en,
    output logic [vcu_pkg::ADDR_W-1:0]  wr_addr,
    output logic                        done
);
    import vcu_pkg::*;

    vcu_state_e        state;
    vcu_state_e        next_state;
    logic              rd_pend;
    logic              xform_q;
    logic              last_vec;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] vec_left;

    assign capture   = work_en && (state == ST_IDLE);
    assign cfg_load  = (state == ST_CONFIG);
    // read in the first load cycle and capture in the second
    assign acc_rd.en   = (state == ST_LOAD) && !rd_pend;
    assign acc_rd.addr = rd_addr;
    assign lane_load = (state == ST_LOAD) && rd_pend;
    assign seq_start = lane_load && xform_q;
    assign wr_en     = (state == ST_WRITE);
    assign last_vec  = (vec_left == '0);

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (capture)
                begin
                    next_state = (insn.kind == KIND_CONFIG) ? ST_CONFIG : ST_LOAD;
                end
            end
            ST_LOAD:
            begin
                if (rd_pend)
                begin
                    next_state = xform_q ? ST_COMPUTE : ST_WRITE;
                end
            end
            ST_COMPUTE:
            begin
                if (seq_done)
                begin
                    next_state = ST_WRITE;
                end
            end
            ST_WRITE:   next_state = last_vec ? ST_IDLE : ST_LOAD;
            ST_CONFIG:  next_state = ST_IDLE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= ST_IDLE;
            rd_pend <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            state   <= next_state;
            rd_pend <= acc_rd.en;
            done    <= (state == ST_CONFIG) || (wr_en && last_vec);
        end
    end

    ////////////////////////////////////////////////////////////
    // address and vector counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_addr  <= '0;
            wr_addr  <= '0;
            vec_left <= '0;
            xform_q  <= 1'b0;
        end
        else if (capture)
        begin
            rd_addr  <= insn.src_addr;
            wr_addr  <= insn.dst_addr;
            vec_left <= insn.count;
            xform_q  <= insn.xform;
        end
        else
        begin
            if (acc_rd.en)
            begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (wr_en)
            begin
                wr_addr  <= wr_addr + 1'b1;
                vec_left <= vec_left - 1'b1;
            end
        end
    end

endmodule

// File: src/vcu_opcode_ram.sv
`timescale 1ns/10ps

module vcu_opcode_ram (
    input  logic                            clk,
    input  vcu_pkg::prog_wr_t               wr,
    input  logic                            rd_en,
    input  logic [vcu_pkg::PROG_ADDR_W-1:0] rd_addr,
    output vcu_pkg::vcu_microop_t           rd_data
);
    import vcu_pkg::*;

    vcu_microop_t mem [1 << PROG_ADDR_W];

    // load port and registered read port
    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/vcu_sequencer.sv
`timescale 1ns/10ps

module vcu_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [vcu_pkg::PROG_ADDR_W-1:0] prog_addr,
    input  logic [vcu_pkg::PROG_LEN_W-1:0]  prog_len,
    input  vcu_pkg::prog_wr_t               prog_wr,
    output vcu_pkg::vcu_op_e                op,
    output logic                            op_valid,
    output logic                            done
);
    import vcu_pkg::*;

    logic [PROG_ADDR_W-1:0] rd_addr;
    logic [PROG_ADDR_W-1:0] next_addr;
    logic [PROG_LEN_W-1:0]  left;
    logic                   issue;
    logic                   last_issue;
    logic                   last_op;
    vcu_microop_t           rd_data;

    // first read goes out in the start cycle itself
    assign issue      = start ? (prog_len != '0) : (left != '0);
    assign last_issue = issue && (start ? (prog_len == 1'b1) : (left == 1'b1));
    assign rd_addr    = start ? prog_addr : next_addr;
    assign op         = rd_data.op;

    vcu_opcode_ram u_opcode_ram (
        .clk     (clk),
        .wr      (prog_wr),
        .rd_en   (issue),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            next_addr <= rd_addr + 1'b1;
        end
    end

    // op_valid trails each read by the ram latency
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            left     <= '0;
            op_valid <= 1'b0;
            last_op  <= 1'b0;
            done     <= 1'b0;
        end
        else
        begin
            op_valid <= issue;
            last_op  <= last_issue;
            done     <= last_op || (start && (prog_len == '0));
            if (start)
            begin
                left <= (prog_len != '0) ? prog_len - 1'b1 : '0;
            end
            else if (issue)
            begin
                left <= left - 1'b1;
            end
        end
    end

endmodule

// File: src/vcu_lane.sv
`timescale 1ns/10ps

module vcu_lane (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  vcu_pkg::lane_t       load_data,
    input  vcu_pkg::vcu_op_e     op,
    input  logic                 op_valid,
    input  vcu_pkg::vcu_consts_t consts,
    output vcu_pkg::lane_t       result
);
    import vcu_pkg::*;

    lane_t work_q;
    lane_t scratch_q;
    lane_t alu;

    // all arithmetic wraps at lane width
    always_comb
    begin
        case (op)
            OP_ADD_C: alu = work_q + consts.add_const;
            OP_MUL_C: alu = work_q * consts.mul_const;
            OP_MAX_C: alu = ($signed(work_q) > $signed(consts.cmp_const)) ?
                            work_q : consts.cmp_const;
            OP_ADD_S: alu = work_q + scratch_q;
            default:  alu = work_q;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            work_q    <= '0;
            scratch_q <= '0;
        end
        else if (load)
        begin
            work_q    <= load_data;
            scratch_q <= '0;
        end
        else if (op_valid)
        begin
            work_q <= alu;
            if (op == OP_SAVE)
            begin
                scratch_q <= work_q;
            end
        end
    end

    assign result = work_q;

endmodule

// File: src/vcu_top.sv
`timescale 1ns/10ps

module vcu_top (
    input  logic                clk,
    input  logic                rst,
    input  vcu_pkg::vcu_insn_t  insn,
    input  logic                work_en,
    input  vcu_pkg::prog_wr_t   prog_wr,
    output vcu_pkg::ram_rd_t    acc_rd,
    input  vcu_pkg::vec_t       acc_rd_data,
    output vcu_pkg::ram_wr_t    ofmap_wr,
    output logic                done
);
    import vcu_pkg::*;

    logic              capture;
    logic              cfg_load;
    logic              lane_load;
    logic              seq_start;
    logic              seq_done;
    logic              op_valid;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    vcu_insn_t         insn_q;
    vcu_consts_t       consts;
    vcu_op_e           op;
    vec_t              results;

    vcu_insn_regs u_insn_regs (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .cfg_load (cfg_load),
        .insn_in  (insn),
        .insn     (insn_q),
        .consts   (consts)
    );

    // the FSM branches on the live word in the capture cycle
    vcu_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .work_en   (work_en),
        .insn      (insn),
        .capture   (capture),
        .cfg_load  (cfg_load),
        .acc_rd    (acc_rd),
        .lane_load (lane_load),
        .seq_start (seq_start),
        .seq_done  (seq_done),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .done      (done)
    );

    vcu_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (seq_start),
        .prog_addr (insn_q.prog_addr),
        .prog_len  (insn_q.prog_len),
        .prog_wr   (prog_wr),
        .op        (op),
        .op_valid  (op_valid),
        .done      (seq_done)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        vcu_lane u_lane (
            .clk       (clk),
            .rst       (rst),
            .load      (lane_load),
            .load_data (acc_rd_data[i]),
            .op        (op),
            .op_valid  (op_valid),
            .consts    (consts),
            .result    (results[i])
        );
    end

    assign ofmap_wr.en   = wr_en;
    assign ofmap_wr.addr = wr_addr;
    assign ofmap_wr.data = results;

endmodule

// File: verification/vcu_clk_gen.sv
`timescale 1ns/10ps

module vcu_clk_gen (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
    end

    // 100 ns period
    always #50 clk = ~clk;

endmodule

// File: verification/vcu_props.sv
`timescale 1ns/10ps

module vcu_props (
    input logic clk,
    input logic rst,
    input logic done,
    input logic wr_en,
    input logic rd_en
);
    // done and write strobe are single-cycle pulses
    done_pulse_a: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for two cycles");

    wr_pulse_a: assert property (@(posedge clk) disable iff (rst) wr_en |=> !wr_en)
        else $error("ofmap_wr.en stayed high for two cycles");

    // no reads while in reset
    rd_in_rst_a: assert property (@(posedge clk) rst |-> (rd_en !== 1'b1))
        else $error("acc_rd.en high during reset");

endmodule

// File: verification/vcu_tb.sv
`timescale 1ns/10ps

module vcu_tb;
    import vcu_pkg::*;

    typedef struct packed {
        logic                   is_cfg;
        logic                   xform;
        logic                   poke;
        logic [ADDR_W-1:0]      src;
        logic [ADDR_W-1:0]      dst;
        logic [ADDR_W-1:0]      count;
        logic [PROG_ADDR_W-1:0] prog_addr;
        logic [PROG_LEN_W-1:0]  prog_len;
        logic [0:3][3:0]        ops;
        vcu_consts_t            consts;
        logic [ADDR_W:0]        n_writes;
    } row_t;

    logic        clk;
    logic        rst = 1'b1;
    logic        work_en = 1'b0;
    vcu_insn_t   insn = '0;
    prog_wr_t    prog_wr = '0;
    vec_t        acc_rd_data = '0;
    ram_rd_t     acc_rd;
    ram_wr_t     ofmap_wr;
    logic        done;

    vec_t        acc_mem [1 << ADDR_W];
    vcu_consts_t model_consts;
    logic [31:0] lfsr_state;
    row_t        rows [$];

    vcu_clk_gen u_clk_gen (
        .clk (clk)
    );

    vcu_top u_vcu_top (
        .clk         (clk),
        .rst         (rst),
        .insn        (insn),
        .work_en     (work_en),
        .prog_wr     (prog_wr),
        .acc_rd      (acc_rd),
        .acc_rd_data (acc_rd_data),
        .ofmap_wr    (ofmap_wr),
        .done        (done)
    );

    bind vcu_top vcu_props u_props (
        .clk   (clk),
        .rst   (rst),
        .done  (done),
        .wr_en (ofmap_wr.en),
        .rd_en (acc_rd.en)
    );

    // accumulator RAM with a one cycle read latency
    always @(posedge clk)
    begin
        if (acc_rd.en)
        begin
            acc_rd_data <= acc_mem[acc_rd.addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_acc_mem();
        lane_t v;
        lfsr_state = 32'hc892_fea0;
        for (int a = 0; a < (1 << ADDR_W); a++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                v = '0;
                for (int b = 0; b < LANE_W; b++)
                begin
                    lfsr_state = lfsr_next(lfsr_state);
                    v = {v[LANE_W-2:0], lfsr_state[0]};
                end
                acc_mem[a][l] = v;
            end
        end
    endtask

    // lane rules applied step by step
    function automatic lane_t ref_lane(input lane_t x, input row_t r, input vcu_consts_t c);
        lane_t              work;
        lane_t              scratch;
        logic signed [31:0] prod;
        work = x;
        scratch = '0;
        if (!r.xform)
        begin
            return x;
        end
        for (int j = 0; j < int'(r.prog_len); j++)
        begin
            case (vcu_op_e'(r.ops[j]))
                OP_ADD_C: work = work + c.add_const;
                OP_MUL_C:
                begin
                    prod = work * c.mul_const;
                    work = prod[LANE_W-1:0];
                end
                OP_MAX_C:
                begin
                    if (work < c.cmp_const)
                    begin
                        work = c.cmp_const;
                    end
                end
                OP_SAVE:  scratch = work;
                OP_ADD_S: work = work + scratch;
                default:  work = work;
            endcase
        end
        return work;
    endfunction

    function automatic row_t compute_row(input logic xform, input logic [ADDR_W-1:0] src,
                                         input logic [ADDR_W-1:0] dst,
                                         input logic [ADDR_W-1:0] count,
                                         input logic [PROG_ADDR_W-1:0] paddr,
                                         input logic [PROG_LEN_W-1:0] plen,
                                         input logic [15:0] ops, input logic poke,
                                         input int n_writes);
        row_t r;
        r = '0;
        r.xform     = xform;
        r.src       = src;
        r.dst       = dst;
        r.count     = count;
        r.prog_addr = paddr;
        r.prog_len  = plen;
        r.ops       = ops;
        r.poke      = poke;
        r.n_writes  = (ADDR_W+1)'(n_writes);
        return r;
    endfunction

    function automatic row_t config_row(input lane_t add_c, input lane_t mul_c,
                                        input lane_t cmp_c);
        row_t r;
        r = '0;
        r.is_cfg           = 1'b1;
        r.consts.add_const = add_c;
        r.consts.mul_const = mul_c;
        r.consts.cmp_const = cmp_c;
        return r;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic watch_quiet(input int n);
        for (int c = 0; c < n; c++)
        begin
            @(negedge clk);
            assert ((ofmap_wr.en === 1'b0) && (done === 1'b0) && (acc_rd.en === 1'b0))
            else stop_run($sformatf("unexpected activity at %0t while idle", $time));
        end
    endtask

    task automatic load_program(input row_t r);
        for (int j = 0; j < int'(r.prog_len); j++)
        begin
            @(posedge clk);
            prog_wr.en        <= 1'b1;
            prog_wr.addr      <= r.prog_addr + PROG_ADDR_W'(j);
            prog_wr.data.op   <= vcu_op_e'(r.ops[j]);
            prog_wr.data.rsvd <= '0;
        end
        @(posedge clk);
        prog_wr.en <= 1'b0;
    endtask

    task automatic issue_insn(input row_t r);
        vcu_insn_t   ci;
        vcu_config_t cw;
        ci = '0;
        cw = '0;
        if (r.is_cfg)
        begin
            cw.kind      = KIND_CONFIG;
            cw.add_const = r.consts.add_const;
            cw.mul_const = r.consts.mul_const;
            cw.cmp_const = r.consts.cmp_const;
            ci = vcu_insn_t'(cw);
        end
        else
        begin
            ci.kind      = KIND_COMPUTE;
            ci.xform     = r.xform;
            ci.src_addr  = r.src;
            ci.dst_addr  = r.dst;
            ci.count     = r.count;
            ci.prog_addr = r.prog_addr;
            ci.prog_len  = r.prog_len;
        end
        @(posedge clk);
        insn    <= ci;
        work_en <= 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // program, instruction and checked writes for one table row
    ////////////////////////////////////////////////////////////

    task automatic run_row(input row_t r);
        vec_t              exp_data;
        logic [ADDR_W-1:0] exp_addr;
        logic [ADDR_W-1:0] rd_addr;
        vcu_config_t       junk;
        int                writes;
        int                k;
        bit                seen_done;
        junk = '0;
        junk.kind = KIND_CONFIG;
        junk.add_const = 16'h5555;
        if (!r.is_cfg && r.xform && (r.prog_len != '0))
        begin
            load_program(r);
        end
        issue_insn(r);
        writes = 0;
        k = 0;
        seen_done = 1'b0;
        while (!seen_done)
        begin
            assert (k < 300) else stop_run("timeout waiting for done");
            @(posedge clk);
            // stray work_en mid-run must be ignored
            work_en <= r.poke && (k == 3);
            if (r.poke && (k == 3))
            begin
                insn <= vcu_insn_t'(junk);
            end
            @(negedge clk);
            if (ofmap_wr.en)
            begin
                assert (writes < int'(r.n_writes))
                else stop_run($sformatf("extra write at %0t", $time));
                exp_addr = r.dst + ADDR_W'(writes);
                rd_addr  = r.src + ADDR_W'(writes);
                for (int i = 0; i < LANES; i++)
                begin
                    exp_data[i] = ref_lane(acc_mem[rd_addr][i], r, model_consts);
                end
                assert (ofmap_wr.addr == exp_addr)
                else stop_run($sformatf("mismatch at %0t: ofmap_wr.addr got %h expected %h",
                                        $time, ofmap_wr.addr, exp_addr));
                assert (ofmap_wr.data == exp_data)
                else stop_run($sformatf("mismatch at %0t: ofmap_wr.data got %h expected %h",
                                        $time, ofmap_wr.data, exp_data));
                writes++;
            end
            if (done)
            begin
                assert (writes == int'(r.n_writes))
                else stop_run($sformatf("mismatch at %0t: write count got %0d expected %0d",
                                        $time, writes, r.n_writes));
                seen_done = 1'b1;
            end
            k++;
        end
        if (r.is_cfg)
        begin
            model_consts = r.consts;
        end
        watch_quiet(3);
    endtask

    initial
    begin
        model_consts.add_const = 16'sd0;
        model_consts.mul_const = 16'sd1;
        model_consts.cmp_const = 16'sd0;
        fill_acc_mem();

        // xform src dst count prog_addr prog_len ops poke writes
        rows.push_back(compute_row(1'b0, 12'h010, 12'h100, 12'd3, 10'h000, 5'd0,
                                   16'h0000, 1'b0, 4));
        rows.push_back(compute_row(1'b1, 12'h020, 12'h200, 12'd1, 10'h000, 5'd3,
                                   {OP_ADD_C, OP_MUL_C, OP_MAX_C, OP_NOP}, 1'b0, 2));
        rows.push_back(config_row(16'h7fff, 16'hfffd, 16'hff00));
        rows.push_back(compute_row(1'b1, 12'h030, 12'h210, 12'd2, 10'h000, 5'd3,
                                   {OP_ADD_C, OP_MUL_C, OP_MAX_C, OP_NOP}, 1'b0, 3));
        rows.push_back(compute_row(1'b1, 12'h040, 12'h300, 12'd3, 10'h2a0, 5'd4,
                                   {OP_ADD_S, OP_SAVE, OP_ADD_S, OP_ADD_C}, 1'b0, 4));
        rows.push_back(compute_row(1'b0, 12'h050, 12'h400, 12'd5, 10'h000, 5'd0,
                                   16'h0000, 1'b1, 6));
        rows.push_back(compute_row(1'b1, 12'h060, 12'h4ff, 12'd0, 10'h3ff, 5'd1,
                                   {OP_ADD_C, OP_NOP, OP_NOP, OP_NOP}, 1'b0, 1));
        rows.push_back(compute_row(1'b1, 12'h070, 12'h500, 12'd1, 10'h000, 5'd0,
                                   16'h0000, 1'b0, 2));

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        watch_quiet(6);

        foreach (rows[n])
        begin
            run_row(rows[n]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
src/vcu_pkg.sv
src/vcu_insn_regs.sv
src/vcu_ctrl.sv
src/vcu_opcode_ram.sv
src/vcu_sequencer.sv
src/vcu_lane.sv
src/vcu_top.sv
verification/vcu_clk_gen.sv
verification/vcu_props.sv
verification/vcu_tb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= vcu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
